//--- Bender.yml
package:
  name: cam_display

sources:
  - common/video_pkg.sv
  - cam_capture/cam_capture.sv
  - pixel_fifo/pixel_fifo.sv
  - sync_gen/sync_gen.sv
  - verilog/video_out.sv
  - verilog/cam_display_top.sv
  - target: test
    files:
      - tests/cam_display_checker.sv
      - tests/tb_cam_display.sv

//--- cam_capture/cam_capture.sv
`timescale 1ns/100ps
`default_nettype none

module cam_capture (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      cam_href,
    input  wire                      cam_vsync,
    input  wire video_pkg::pixel_t   cam_data,
    input  wire                      cap_ready,
    output logic                     cap_valid,
    output video_pkg::pixel_t        cap_data,
    output logic                     cap_last,
    output logic                     overflow
);

    logic                  href_q;
    logic                  vsync_q;
    video_pkg::pixel_t     data_q;
    video_pkg::cap_state_t state;
    logic                  line_end;

    assign line_end = href_q & ~cam_href;  // The next sample drops href so data_q closes the line

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            href_q  <= cam_href;
            vsync_q <= cam_vsync;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= cam_data;
    end

    // LINE is entered one sample ahead so it covers every href_q pixel of the line
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            state <= video_pkg::CAP_WAIT_FRAME;
        end else begin
            case (state)
                video_pkg::CAP_WAIT_FRAME: begin
                    if (vsync_q) begin
                        state <= video_pkg::CAP_BLANK;
                    end
                end
                video_pkg::CAP_BLANK: begin
                    if (cam_href) begin
                        state <= video_pkg::CAP_LINE;
                    end
                end
                video_pkg::CAP_LINE: begin
                    if (line_end) begin
                        state <= video_pkg::CAP_BLANK;
                    end
                end
                default: begin
                    state <= video_pkg::CAP_WAIT_FRAME;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            cap_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            cap_valid <= href_q && (state == video_pkg::CAP_LINE);
            if (cap_valid && !cap_ready) begin
                overflow <= 1'b1;  // The camera cannot wait so this pixel is lost
            end
        end
    end

    always_ff @(posedge clk) begin
        cap_data <= data_q;
        cap_last <= line_end;
    end

endmodule : cam_capture

`default_nettype wire

//--- common/video_pkg.sv
`default_nettype none

package video_pkg;

    localparam int PIX_W = 8;  // Width of the camera data bus

    typedef logic [PIX_W-1:0] pixel_t;

    // Output line timing phases
    typedef enum logic [1:0] {
        SYNC_IDLE,
        SYNC_FP,
        SYNC_PULSE,
        SYNC_ACTIVE
    } sync_state_t;

    // Camera capture phases
    typedef enum logic [1:0] {
        CAP_WAIT_FRAME,
        CAP_LINE,
        CAP_BLANK
    } cap_state_t;

endpackage : video_pkg

`default_nettype wire

//--- pixel_fifo/pixel_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_fifo #(
    parameter int FIFO_DEPTH = 2048
) (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      in_valid,
    input  wire video_pkg::pixel_t   in_data,
    input  wire                      in_last,
    input  wire                      out_ready,
    output logic                     in_ready,
    output logic                     out_valid,
    output video_pkg::pixel_t        out_data,
    output logic                     out_last
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [video_pkg::PIX_W:0] mem [FIFO_DEPTH];  // Line flag stored above the pixel
    logic [AW:0]               wr_ptr;
    logic [AW:0]               rd_ptr;
    logic [AW:0]               rd_ptr_nxt;
    logic                      full;
    logic                      do_write;
    logic                      do_read;

    assign full       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign in_ready   = ~full;
    assign do_write   = in_valid & ~full;
    assign do_read    = out_valid & out_ready;
    assign rd_ptr_nxt = do_read ? rd_ptr + 1'b1 : rd_ptr;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= {in_last, in_data};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr    <= rd_ptr_nxt;
            out_valid <= (wr_ptr != rd_ptr_nxt);  // Sees the write pointer of the last cycle
        end
    end

    assign {out_last, out_data} = mem[rd_ptr[AW-1:0]];

endmodule : pixel_fifo

`default_nettype wire

//--- project.f
common/video_pkg.sv
cam_capture/cam_capture.sv
pixel_fifo/pixel_fifo.sv
sync_gen/sync_gen.sv
verilog/video_out.sv
verilog/cam_display_top.sv
tests/cam_display_checker.sv
tests/tb_cam_display.sv

//--- sync_gen/sync_gen.sv
`timescale 1ns/100ps
`default_nettype none

module sync_gen #(
    parameter int H_ACT   = 1280,
    parameter int H_FP    = 150,
    parameter int H_SYNC  = 40,
    parameter int V_DELAY = 5
) (
    input  wire  clk,
    input  wire  rstn,
    input  wire  cam_href,
    input  wire  cam_vsync,
    output logic hsync,
    output logic vsync,
    output logic de
);

    localparam int H_MAX = (H_ACT > H_FP) ? ((H_ACT > H_SYNC) ? H_ACT : H_SYNC)
                                          : ((H_FP > H_SYNC) ? H_FP : H_SYNC);
    localparam int HCW   = $clog2(H_MAX + 1);
    localparam int VCW   = $clog2(V_DELAY + 2);  // Saturates one line past V_DELAY

    logic                   href_d;
    logic                   vsync_d;
    logic                   locked;
    logic                   line_start;
    logic                   frame_start;
    logic [HCW-1:0]         h_cnt;
    logic [VCW-1:0]         v_cnt;
    video_pkg::sync_state_t state;

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            href_d  <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            href_d  <= cam_href;
            vsync_d <= cam_vsync;
        end
    end

    assign frame_start = cam_vsync & ~vsync_d;

    // A camera line end restarts the output line unless porch or sync is still running
    assign line_start = href_d & ~cam_href & locked &
                        ((state == video_pkg::SYNC_IDLE) || (state == video_pkg::SYNC_ACTIVE));

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            locked <= 1'b0;
            v_cnt  <= '0;
        end else begin
            if (frame_start) begin
                locked <= 1'b1;
                v_cnt  <= '0;
            end else if (line_start && (v_cnt <= VCW'(V_DELAY))) begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            state <= video_pkg::SYNC_IDLE;
            h_cnt <= '0;
        end else if (line_start) begin
            state <= video_pkg::SYNC_FP;
            h_cnt <= '0;
        end else begin
            case (state)
                video_pkg::SYNC_FP: begin
                    if (h_cnt == HCW'(H_FP - 1)) begin
                        h_cnt <= '0;
                        state <= video_pkg::SYNC_PULSE;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                video_pkg::SYNC_PULSE: begin
                    if (h_cnt == HCW'(H_SYNC - 1)) begin
                        h_cnt <= '0;
                        state <= video_pkg::SYNC_ACTIVE;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                video_pkg::SYNC_ACTIVE: begin
                    if (h_cnt == HCW'(H_ACT - 1)) begin
                        h_cnt <= '0;
                        state <= video_pkg::SYNC_IDLE;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: begin
                    h_cnt <= '0;
                    state <= video_pkg::SYNC_IDLE;
                end
            endcase
        end
    end

    assign hsync = (state == video_pkg::SYNC_PULSE);
    assign de    = (state == video_pkg::SYNC_ACTIVE);
    assign vsync = hsync && (v_cnt == VCW'(V_DELAY));  // Only on output line V_DELAY of the frame

endmodule : sync_gen

`default_nettype wire

//--- tests/cam_display_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cam_display_checker #(
    parameter int H_SYNC     = 40,
    parameter int FIFO_DEPTH = 2048
) (
    input wire                         clk,
    input wire                         rstn,
    input wire [$clog2(FIFO_DEPTH):0]  fifo_wr_ptr,
    input wire [$clog2(FIFO_DEPTH):0]  fifo_rd_ptr,
    input wire                         fifo_write,
    input wire                         fifo_out_valid,
    input wire                         fifo_out_ready,
    input wire video_pkg::cap_state_t  cap_state,
    input wire video_pkg::sync_state_t sync_state,
    input wire                         hsync,
    input wire                         de
);

    localparam int AW = $clog2(FIFO_DEPTH);

    int          fail_count = 0;  // Read by the testbench
    logic [AW:0] occupancy;

    assign occupancy = fifo_wr_ptr - fifo_rd_ptr;  // Wraps the same way as the FIFO pointers

    no_write_when_full: assert property (@(posedge clk) disable iff (!rstn)
        int'(occupancy) <= FIFO_DEPTH)
        else begin
            $error("FIFO written while full");
            fail_count++;
        end

    no_write_before_frame: assert property (@(posedge clk) disable iff (!rstn)
        (cap_state == video_pkg::CAP_WAIT_FRAME) |-> !fifo_write)
        else begin
            $error("FIFO written before the first camera frame");
            fail_count++;
        end

    valid_held: assert property (@(posedge clk) disable iff (!rstn)
        fifo_out_valid && !fifo_out_ready |=> fifo_out_valid)
        else begin
            $error("FIFO out_valid dropped before the word was taken");
            fail_count++;
        end

    hsync_width: assert property (@(posedge clk) disable iff (!rstn)
        $rose(hsync) |-> hsync [*H_SYNC] ##1 !hsync)
        else begin
            $error("hsync pulse width differs from H_SYNC");
            fail_count++;
        end

    active_after_sync: assert property (@(posedge clk) disable iff (!rstn)
        $fell(hsync) |-> (sync_state == video_pkg::SYNC_ACTIVE))
        else begin
            $error("Active phase does not follow the sync pulse");
            fail_count++;
        end

    de_hsync_apart: assert property (@(posedge clk) disable iff (!rstn)
        !(de && hsync))
        else begin
            $error("de and hsync high together");
            fail_count++;
        end

endmodule : cam_display_checker

bind cam_display_top cam_display_checker #(
    .H_SYNC     (H_SYNC),
    .FIFO_DEPTH (FIFO_DEPTH)
) chk_i (
    .clk            (clk),
    .rstn           (rstn),
    .fifo_wr_ptr    (fifo_i.wr_ptr),
    .fifo_rd_ptr    (fifo_i.rd_ptr),
    .fifo_write     (fifo_i.do_write),
    .fifo_out_valid (fifo_i.out_valid),
    .fifo_out_ready (fifo_i.out_ready),
    .cap_state      (capture_i.state),
    .sync_state     (video_out_i.sync_gen_i.state),
    .hsync          (hsync),
    .de             (de)
);

`default_nettype wire

//--- tests/tb_cam_display.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cam_display;

    localparam int H_ACT      = 16;
    localparam int H_FP       = 4;
    localparam int H_SYNC     = 3;
    localparam int V_DELAY    = 1;
    localparam int FIFO_DEPTH = 32;
    localparam int N_ROWS     = 4;

    typedef struct {
        int lines;
        int blank;
        bit rnd;
        bit long_line;
    } row_t;

    // Lines per frame, blank cycles per line, random pixels, long line
    row_t rows [N_ROWS] = '{
        '{3, 8, 1'b0, 1'b0},
        '{2, 12, 1'b1, 1'b0},
        '{1, 10, 1'b0, 1'b1},
        '{2, 9, 1'b1, 1'b0}
    };

    logic              clk;
    logic              rstn;
    logic              cam_href;
    logic              cam_vsync;
    video_pkg::pixel_t cam_data;
    logic              hsync;
    logic              vsync;
    logic              de;
    video_pkg::pixel_t pix_out;
    logic              overflow;
    logic              underrun;

    video_pkg::pixel_t exp_q [$];
    video_pkg::pixel_t inc_val;
    int                occ;  // Model of the FIFO occupancy
    int                frame_lines;
    int                hs_cnt;
    int                vs_cnt;
    int                de_cnt;
    int                cycles;
    int                limit;
    bit                framed;
    bit                de_q;
    bit                ovf_exp;

    cam_display_top #(
        .H_ACT      (H_ACT),
        .H_FP       (H_FP),
        .H_SYNC     (H_SYNC),
        .V_DELAY    (V_DELAY),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .cam_data  (cam_data),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .pix_out   (pix_out),
        .overflow  (overflow),
        .underrun  (underrun)
    );

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_pixel(input video_pkg::pixel_t got, input video_pkg::pixel_t exp,
                               input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s expected 0x%02h, got 0x%02h", what, exp, got));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s expected %b, got %b", what, exp, got));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_mismatch($sformatf("%s expected %0d, got %0d", what, exp, got));
        end
    endtask

    function automatic int timeout_cycles();
        int total;
        total = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total += rows[r].lines *
                     ((rows[r].long_line ? 2 * FIFO_DEPTH : H_ACT) + rows[r].blank);
        end
        return 2 * total + 200;
    endfunction

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            cam_href  = 1'b0;
            cam_vsync = 1'b0;
            cam_data  = '0;
        end
    endtask

    task automatic send_vsync();
        repeat (2) begin
            @(posedge clk);
            #1;
            cam_vsync = 1'b1;
            framed    = 1'b1;
        end
    endtask

    // A lossy line stops its expected pixels once the modelled FIFO is full
    task automatic send_line(input int n_pix, input int blank, input bit rnd, input bit lossy,
                             input bit record);
        video_pkg::pixel_t px;
        for (int i = 0; i < n_pix; i++) begin
            @(posedge clk);
            #1;
            if (rnd) begin
                px = video_pkg::pixel_t'($urandom);
            end else begin
                px = inc_val;
                inc_val++;
            end
            cam_href = 1'b1;
            cam_data = px;
            if (record && (!lossy || occ < FIFO_DEPTH)) begin
                exp_q.push_back(px);
                occ++;
            end
        end
        drive_idle(blank);
    endtask

    task automatic play_frame(input row_t row);
        send_vsync();
        drive_idle(6);
        for (int l = 0; l < row.lines; l++) begin
            send_line(row.long_line ? 2 * FIFO_DEPTH : H_ACT, row.blank, row.rnd,
                      row.long_line, 1'b1);
        end
        drive_idle(H_FP + H_SYNC + H_ACT + 6);  // Let the last output line finish
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        limit  = timeout_cycles();
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        fail_plain($sformatf("Timeout: the run did not end within %0d clock cycles", limit));
    end

    always @(negedge clk) begin
        check_count(dut_i.chk_i.fail_count, 0, "checker assertion failures");
        if (!rstn || !framed) begin
            check_flag(hsync, 1'b0, "hsync before the first frame");
            check_flag(vsync, 1'b0, "vsync before the first frame");
            check_flag(de, 1'b0, "de before the first frame");
            check_flag(overflow, 1'b0, "overflow before the first frame");
            check_flag(underrun, 1'b0, "underrun before the first frame");
        end
        if (cam_vsync) begin
            frame_lines = 0;
        end
        if (vsync) begin
            check_flag(hsync, 1'b1, "hsync during vsync");
            vs_cnt++;
        end
        if (hsync) begin
            hs_cnt++;
        end
        if (de) begin
            if (exp_q.size() == 0) begin
                fail_plain("The display showed a pixel that the camera never sent");
            end
            check_pixel(pix_out, exp_q.pop_front(), "pix_out");
            occ--;
            de_cnt++;
        end else if (de_q) begin
            frame_lines++;  // Falling de closes an output line
            check_count(hs_cnt, H_SYNC, "hsync cycles in line");
            check_count(de_cnt, H_ACT, "de cycles in line");
            check_count(vs_cnt, (frame_lines == V_DELAY) ? H_SYNC : 0, "vsync cycles in line");
            hs_cnt = 0;
            vs_cnt = 0;
            de_cnt = 0;
        end
        de_q = de;
    end

    initial begin
        rstn        = 1'b0;
        cam_href    = 1'b0;
        cam_vsync   = 1'b0;
        cam_data    = '0;
        inc_val     = '0;
        occ         = 0;
        frame_lines = 0;
        hs_cnt      = 0;
        vs_cnt      = 0;
        de_cnt      = 0;
        framed      = 1'b0;
        de_q        = 1'b0;
        ovf_exp     = 1'b0;
        void'($urandom(32'h2354));
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        drive_idle(4);
        send_line(H_ACT, 8, 1'b0, 1'b0, 1'b0);  // Camera runs before any vsync
        drive_idle(H_FP + H_SYNC + H_ACT);
        for (int r = 0; r < N_ROWS; r++) begin
            play_frame(rows[r]);
            check_count(frame_lines, rows[r].lines, "output lines in frame");
            if (rows[r].long_line) begin
                ovf_exp = 1'b1;
            end
            check_flag(overflow, ovf_exp, "overflow flag");
            check_flag(underrun, 1'b0, "underrun flag");
        end
        if (dut_i.chk_i.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_cam_display

`default_nettype wire

//--- verilog/cam_display_top.sv
`timescale 1ns/100ps
`default_nettype none

module cam_display_top #(
    parameter int H_ACT      = 1280,
    parameter int H_FP       = 150,
    parameter int H_SYNC     = 40,
    parameter int V_DELAY    = 5,
    parameter int FIFO_DEPTH = 2048  // Power of two, at least H_ACT
) (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      cam_href,
    input  wire                      cam_vsync,
    input  wire video_pkg::pixel_t   cam_data,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de,
    output video_pkg::pixel_t        pix_out,
    output logic                     overflow,
    output logic                     underrun
);

    logic              cap_valid;
    logic              cap_ready;
    video_pkg::pixel_t cap_data;
    logic              cap_last;
    logic              out_valid;
    logic              out_ready;
    video_pkg::pixel_t out_data;

    cam_capture capture_i (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .cam_data  (cam_data),
        .cap_ready (cap_ready),
        .cap_valid (cap_valid),
        .cap_data  (cap_data),
        .cap_last  (cap_last),
        .overflow  (overflow)
    );

    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (cap_valid),
        .in_data   (cap_data),
        .in_last   (cap_last),
        .out_ready (out_ready),
        .in_ready  (cap_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  ()
    );

    video_out #(
        .H_ACT   (H_ACT),
        .H_FP    (H_FP),
        .H_SYNC  (H_SYNC),
        .V_DELAY (V_DELAY)
    ) video_out_i (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .pix_out   (pix_out),
        .underrun  (underrun)
    );

endmodule : cam_display_top

`default_nettype wire

//--- verilog/video_out.sv
`timescale 1ns/100ps
`default_nettype none

module video_out #(
    parameter int H_ACT   = 1280,
    parameter int H_FP    = 150,
    parameter int H_SYNC  = 40,
    parameter int V_DELAY = 5
) (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      cam_href,
    input  wire                      cam_vsync,
    input  wire                      out_valid,
    input  wire video_pkg::pixel_t   out_data,
    output logic                     out_ready,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de,
    output video_pkg::pixel_t        pix_out,
    output logic                     underrun
);

    logic hsync_gen;
    logic vsync_gen;
    logic de_gen;

    sync_gen #(
        .H_ACT   (H_ACT),
        .H_FP    (H_FP),
        .H_SYNC  (H_SYNC),
        .V_DELAY (V_DELAY)
    ) sync_gen_i (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .hsync     (hsync_gen),
        .vsync     (vsync_gen),
        .de        (de_gen)
    );

    assign out_ready = de_gen;  // One pop per display-enable cycle

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            de       <= 1'b0;
            underrun <= 1'b0;
        end else begin
            hsync <= hsync_gen;
            vsync <= vsync_gen;
            de    <= de_gen;
            if (de_gen && !out_valid) begin
                underrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pix_out <= (de_gen && out_valid) ? out_data : '0;
    end

endmodule : video_out

`default_nettype wire
